// ==== hw/ps2lcd_defines.svh ====
`ifndef PS2LCD_DEFINES_SVH
`define PS2LCD_DEFINES_SVH

// line filter and frame format
`define PS2_FILTER_DEPTH 8
`define PS2_FRAME_BITS   11

// display geometry and pacing
`define LCD_LINE_CHARS   16
`define LCD_CHARS        32
`define WRITER_GAP       2

// set 2 scan codes
`define SC_BREAK  8'hF0
`define SC_EXTEND 8'hE0
`define SC_LSHIFT 8'h12
`define SC_RSHIFT 8'h59
`define SC_CAPS   8'h58
`define SC_BKSP   8'h66

// HD44780 style codes
`define LCD_CMD_LINE1 8'h80
`define LCD_CMD_LINE2 8'hC0
`define LCD_CMD_LAST  8'hCF
`define LCD_SPACE     8'h20

`endif

// ==== hw/ps2lcd_pkg.sv ====
`default_nettype none

package ps2lcd_pkg;

  typedef logic [7:0] scan_byte_t;
  typedef logic [7:0] ascii_t;
  typedef logic [5:0] cursor_t;  // 0 to 32

  typedef enum logic {
    KEY_CHAR,
    KEY_BKSP
  } key_kind_t;

  typedef struct packed {
    key_kind_t kind;
    ascii_t    ch;
  } key_event_t;

  typedef struct packed {
    logic       cmd;  // high for a command
    logic [7:0] data;
  } lcd_bus_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_SHIFT,
    RX_DONE
  } rx_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT,
    WR_PULSE,
    WR_GAP
  } wr_state_t;

endpackage

`default_nettype wire

// ==== hw/ps2_line_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2lcd_defines.svh"

module ps2_line_filter #(
  parameter int DEPTH = `PS2_FILTER_DEPTH
) (
  input  logic clk,
  input  logic rst,
  input  logic line_in,
  output logic line_out
);

  logic [DEPTH-1:0] hist;
  logic [DEPTH-1:0] hist_next;

  assign hist_next = {hist[DEPTH-2:0], line_in};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist     <= '1;
      line_out <= 1'b1;  // idle level
    end else begin
      hist <= hist_next;
      if (&hist_next) begin
        line_out <= 1'b1;
      end else if (~|hist_next) begin
        line_out <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/ps2_frame_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2lcd_defines.svh"

module ps2_frame_receiver (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ps2_clk_f,
  input  logic                   ps2_data_f,
  output ps2lcd_pkg::scan_byte_t byte_out,
  output logic                   byte_valid
);

  import ps2lcd_pkg::*;

  localparam int CNT_W = $clog2(`PS2_FRAME_BITS + 1);

  rx_state_t                  state;
  logic                       clk_q;
  logic                       fall;
  logic                       shift_en;
  logic [CNT_W-1:0]           bit_cnt;
  logic [`PS2_FRAME_BITS-1:0] frame;

  assign fall = clk_q & ~ps2_clk_f;

  // start bit in idle, every bit after that in shift
  assign shift_en = fall &&
                    ((state == RX_SHIFT) || ((state == RX_IDLE) && !ps2_data_f));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_q   <= 1'b1;
      state   <= RX_IDLE;
      bit_cnt <= '0;
    end else begin
      clk_q <= ps2_clk_f;
      case (state)
        RX_IDLE: begin
          if (shift_en) begin
            state   <= RX_SHIFT;
            bit_cnt <= CNT_W'(1);
          end
        end
        RX_SHIFT: begin
          if (fall) begin
            if (bit_cnt == CNT_W'(`PS2_FRAME_BITS - 1)) begin
              state <= RX_DONE;  // stop bit taken
            end
            bit_cnt <= bit_cnt + CNT_W'(1);
          end
        end
        RX_DONE: begin
          state   <= RX_IDLE;
          bit_cnt <= '0;
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // lsb arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (shift_en) begin
      frame <= {ps2_data_f, frame[`PS2_FRAME_BITS-1:1]};
    end
  end

  assign byte_out   = frame[8:1];  // drop start, parity, stop
  assign byte_valid = (state == RX_DONE);

endmodule

`default_nettype wire

// ==== hw/scan_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2lcd_defines.svh"

module scan_decoder (
  input  logic                   clk,
  input  logic                   rst,
  input  ps2lcd_pkg::scan_byte_t byte_in,
  input  logic                   byte_valid,
  output ps2lcd_pkg::key_event_t ev,
  output logic                   ev_valid,
  input  logic                   ev_ready
);

  import ps2lcd_pkg::*;

  logic       break_seen;
  logic       shift;
  logic       caps;
  logic       take;
  logic       rel_byte;
  logic       is_shift;
  logic       is_letter;
  logic       raise;
  ascii_t     mapped;
  key_event_t next_ev;

  assign take      = byte_valid && !ev_valid;  // bytes dropped while an event waits
  assign is_shift  = (byte_in == `SC_LSHIFT) || (byte_in == `SC_RSHIFT);
  assign rel_byte  = take && break_seen &&
                     (byte_in != `SC_BREAK) && (byte_in != `SC_EXTEND);
  assign is_letter = (mapped >= "a") && (mapped <= "z");
  assign raise     = rel_byte && ((byte_in == `SC_BKSP) || (mapped != '0));

  // lower case ascii per scan code, zero when unmapped
  always_comb begin
    mapped = '0;
    case (byte_in)
      8'h1C: mapped = "a";
      8'h32: mapped = "b";
      8'h21: mapped = "c";
      8'h23: mapped = "d";
      8'h24: mapped = "e";
      8'h2B: mapped = "f";
      8'h34: mapped = "g";
      8'h33: mapped = "h";
      8'h43: mapped = "i";
      8'h3B: mapped = "j";
      8'h42: mapped = "k";
      8'h4B: mapped = "l";
      8'h3A: mapped = "m";
      8'h31: mapped = "n";
      8'h44: mapped = "o";
      8'h4D: mapped = "p";
      8'h15: mapped = "q";
      8'h2D: mapped = "r";
      8'h1B: mapped = "s";
      8'h2C: mapped = "t";
      8'h3C: mapped = "u";
      8'h2A: mapped = "v";
      8'h1D: mapped = "w";
      8'h22: mapped = "x";
      8'h35: mapped = "y";
      8'h1A: mapped = "z";
      8'h45: mapped = "0";
      8'h16: mapped = "1";
      8'h1E: mapped = "2";
      8'h26: mapped = "3";
      8'h25: mapped = "4";
      8'h2E: mapped = "5";
      8'h36: mapped = "6";
      8'h3D: mapped = "7";
      8'h3E: mapped = "8";
      8'h46: mapped = "9";
      8'h29: mapped = `LCD_SPACE;
      default: mapped = '0;
    endcase
  end

  always_comb begin
    next_ev.kind = (byte_in == `SC_BKSP) ? KEY_BKSP : KEY_CHAR;
    if (is_letter && (caps ^ shift)) begin
      next_ev.ch = mapped - 8'h20;  // upper case
    end else begin
      next_ev.ch = mapped;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      break_seen <= 1'b0;
      shift      <= 1'b0;
      caps       <= 1'b0;
      ev_valid   <= 1'b0;
    end else begin
      if (raise) begin
        ev_valid <= 1'b1;
      end else if (ev_ready) begin
        ev_valid <= 1'b0;
      end
      if (take) begin
        if (byte_in == `SC_BREAK) begin
          break_seen <= 1'b1;
        end else if (byte_in != `SC_EXTEND) begin
          break_seen <= 1'b0;
          if (is_shift) begin
            shift <= !break_seen;  // make sets, release clears
          end else if (break_seen && (byte_in == `SC_CAPS)) begin
            caps <= !caps;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (raise) begin
      ev <= next_ev;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lcd_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2lcd_defines.svh"

module lcd_writer (
  input  logic                   clk,
  input  logic                   rst,
  input  ps2lcd_pkg::key_event_t ev,
  input  logic                   ev_valid,
  output logic                   ev_ready,
  input  logic                   busy,
  output ps2lcd_pkg::lcd_bus_t   lcd,
  output logic                   en
);

  import ps2lcd_pkg::*;

  localparam int GAP_W = $clog2(`WRITER_GAP + 1);

  wr_state_t          state;
  cursor_t            cursor;
  cursor_t            load_cursor;
  lcd_bus_t [2:0]     xq;  // pending transfers, entry 0 goes next
  lcd_bus_t [2:0]     load_q;
  logic [1:0]         n_left;
  logic [1:0]         load_n;
  logic [GAP_W-1:0]   gap_cnt;
  logic [4:0]         bk_idx;
  logic [7:0]         bk_addr;

  function automatic lcd_bus_t lcd_cmd(input logic [7:0] code);
    lcd_bus_t b;
    b.cmd  = 1'b1;
    b.data = code;
    return b;
  endfunction

  function automatic lcd_bus_t lcd_dat(input ascii_t ch);
    lcd_bus_t b;
    b.cmd  = 1'b0;
    b.data = ch;
    return b;
  endfunction

  // position left of the cursor, 80h or C0h based
  assign bk_idx  = 5'(cursor - cursor_t'(1));
  assign bk_addr = {1'b1, bk_idx[4], 2'b00, bk_idx[3:0]};

  always_comb begin
    load_q      = '0;
    load_n      = 2'd1;
    load_cursor = cursor + cursor_t'(1);
    if (ev.kind == KEY_CHAR) begin
      if (cursor == cursor_t'(`LCD_CHARS)) begin
        load_q[0]   = lcd_cmd(`LCD_CMD_LINE1);  // wrap to top line
        load_q[1]   = lcd_dat(ev.ch);
        load_n      = 2'd2;
        load_cursor = cursor_t'(1);
      end else if (cursor == cursor_t'(`LCD_LINE_CHARS)) begin
        load_q[0] = lcd_cmd(`LCD_CMD_LINE2);
        load_q[1] = lcd_dat(ev.ch);
        load_n    = 2'd2;
      end else begin
        load_q[0] = lcd_dat(ev.ch);
      end
    end else if (cursor == '0) begin
      load_q[0]   = lcd_cmd(`LCD_CMD_LAST);  // back up into last cell
      load_q[1]   = lcd_dat(`LCD_SPACE);
      load_q[2]   = lcd_cmd(`LCD_CMD_LAST);
      load_n      = 2'd3;
      load_cursor = cursor_t'(`LCD_CHARS - 1);
    end else begin
      load_q[0]   = lcd_cmd(bk_addr);
      load_q[1]   = lcd_dat(`LCD_SPACE);
      load_q[2]   = lcd_cmd(bk_addr);
      load_n      = 2'd3;
      load_cursor = cursor - cursor_t'(1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= WR_IDLE;
      cursor  <= '0;
      xq      <= '0;
      n_left  <= '0;
      gap_cnt <= '0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (ev_valid) begin
            xq     <= load_q;
            n_left <= load_n;
            cursor <= load_cursor;
            state  <= WR_WAIT;
          end
        end
        WR_WAIT: begin
          if (!busy) begin
            state <= WR_PULSE;
          end
        end
        WR_PULSE: begin
          xq      <= {lcd_bus_t'('0), xq[2:1]};
          n_left  <= n_left - 2'd1;
          gap_cnt <= '0;
          state   <= WR_GAP;
        end
        WR_GAP: begin
          // give the display time to raise busy
          if (gap_cnt == GAP_W'(`WRITER_GAP - 1)) begin
            state <= (n_left != '0) ? WR_WAIT : WR_IDLE;
          end else begin
            gap_cnt <= gap_cnt + GAP_W'(1);
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  assign ev_ready = (state == WR_IDLE);
  assign en       = (state == WR_PULSE);
  assign lcd      = xq[0];

endmodule

`default_nettype wire

// ==== hw/ps2_lcd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_lcd_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ps2_clk,
  input  logic                   ps2_data,
  input  logic                   busy,
  output ps2lcd_pkg::lcd_bus_t   lcd,
  output logic                   en,
  output ps2lcd_pkg::scan_byte_t led
);

  import ps2lcd_pkg::*;

  logic [1:0] pins;
  logic [1:0] filt;  // 0 clock, 1 data
  scan_byte_t rx_byte;
  logic       rx_valid;
  key_event_t ev;
  logic       ev_valid;
  logic       ev_ready;

  assign pins = {ps2_data, ps2_clk};

  for (genvar i = 0; i < 2; i++) begin : g_filter
    ps2_line_filter ps2_line_filter_inst (
      .clk      (clk),
      .rst      (rst),
      .line_in  (pins[i]),
      .line_out (filt[i])
    );
  end

  ps2_frame_receiver ps2_frame_receiver_inst (
    .clk        (clk),
    .rst        (rst),
    .ps2_clk_f  (filt[0]),
    .ps2_data_f (filt[1]),
    .byte_out   (rx_byte),
    .byte_valid (rx_valid)
  );

  scan_decoder scan_decoder_inst (
    .clk        (clk),
    .rst        (rst),
    .byte_in    (rx_byte),
    .byte_valid (rx_valid),
    .ev         (ev),
    .ev_valid   (ev_valid),
    .ev_ready   (ev_ready)
  );

  lcd_writer lcd_writer_inst (
    .clk      (clk),
    .rst      (rst),
    .ev       (ev),
    .ev_valid (ev_valid),
    .ev_ready (ev_ready),
    .busy     (busy),
    .lcd      (lcd),
    .en       (en)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      led <= '0;
    end else if (rx_valid) begin
      led <= rx_byte;  // last byte off the wire
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_ps2_lcd_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2lcd_defines.svh"

module tb_ps2_lcd_assertions (
  input logic                   clk,
  input logic                   rst,
  input ps2lcd_pkg::key_event_t ev,
  input logic                   ev_valid,
  input logic                   ev_ready,
  input logic                   busy,
  input logic                   en
);

  a_en_not_busy: assert property (@(posedge clk) disable iff (rst) en |-> !busy)
    else $error("enable pulse while the display is busy");

  // quiet cycles after every pulse
  for (genvar k = 1; k <= `WRITER_GAP; k++) begin : g_gap
    a_gap: assert property (@(posedge clk) disable iff (rst) $past(en, k) |-> !en)
      else $error("enable raised %0d cycles after the previous pulse", k);
  end

  a_ev_hold: assert property (@(posedge clk) disable iff (rst)
    (ev_valid && !ev_ready) |=> (ev_valid && $stable(ev)))
    else $error("pending key event dropped or changed before transfer");

endmodule

bind lcd_writer tb_ps2_lcd_assertions tb_ps2_lcd_assertions_inst (
  .clk      (clk),
  .rst      (rst),
  .ev       (ev),
  .ev_valid (ev_valid),
  .ev_ready (ev_ready),
  .busy     (busy),
  .en       (en)
);

`default_nettype wire

// ==== testbench/tb_ps2_lcd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2lcd_defines.svh"

module tb_ps2_lcd;

  import ps2lcd_pkg::*;

  logic       clk = 1'b0;
  logic       rst;
  logic       ps2_clk;
  logic       ps2_data;
  logic       busy;
  lcd_bus_t   lcd;
  logic       en;
  scan_byte_t led;

  logic [8:0] exp_q[$];  // {cmd, data} in display order
  int         m_cursor;
  logic       m_shift;
  logic       m_caps;
  scan_byte_t shift_code;

  scan_byte_t letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
                                    8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31,
                                    8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C,
                                    8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
  scan_byte_t digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
                                   8'h3D, 8'h3E, 8'h46};

  ps2_lcd_top ps2_lcd_top_inst (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .busy     (busy),
    .lcd      (lcd),
    .en       (en),
    .led      (led)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input string name, input int got, input int want);
    assert (got == want) else begin
      fail_run($sformatf("mismatch at %0d ns: %s expected %h, got %h",
                         $time, name, want, got));
    end
  endtask

  task automatic push_exp(input logic cmd, input logic [7:0] data);
    exp_q.push_back({cmd, data});
  endtask

  task automatic model_char(input ascii_t ch);
    if (m_cursor == `LCD_CHARS) begin
      push_exp(1'b1, `LCD_CMD_LINE1);
      m_cursor = 0;
    end else if (m_cursor == `LCD_LINE_CHARS) begin
      push_exp(1'b1, `LCD_CMD_LINE2);
    end
    push_exp(1'b0, ch);
    m_cursor++;
  endtask

  task automatic model_bksp();
    int         i;
    logic [7:0] addr;
    if (m_cursor == 0) begin
      push_exp(1'b1, `LCD_CMD_LAST);
      push_exp(1'b0, `LCD_SPACE);
      push_exp(1'b1, `LCD_CMD_LAST);
      m_cursor = `LCD_CHARS - 1;
    end else begin
      i    = m_cursor - 1;
      addr = `LCD_CMD_LINE1 + ((i >= `LCD_LINE_CHARS) ? 8'h40 : 8'h00);
      addr = addr + 8'(i % `LCD_LINE_CHARS);
      push_exp(1'b1, addr);
      push_exp(1'b0, `LCD_SPACE);
      push_exp(1'b1, addr);
      m_cursor--;
    end
  endtask

  // start, 8 data bits lsb first, odd parity, stop
  task automatic send_frame(input scan_byte_t code);
    logic [10:0] bits;
    bits = {1'b1, ~^code, code, 1'b0};
    for (int b = 0; b < `PS2_FRAME_BITS; b++) begin
      ps2_data = bits[b];
      repeat (20) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (40) @(negedge clk);
      ps2_clk = 1'b1;
      repeat (20) @(negedge clk);
    end
    repeat (100) @(negedge clk);  // idle between frames
  endtask

  task automatic send_key(input scan_byte_t code);
    send_frame(code);
    send_frame(`SC_BREAK);
    send_frame(code);
    check_eq("led", int'(led), int'(code));
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((exp_q.size() != 0) || !ps2_lcd_top_inst.lcd_writer_inst.ev_ready) begin
      @(negedge clk);
      n++;
      if (n > 5000) begin
        fail_run("timeout waiting for the lcd writer to finish its transfers");
      end
    end
  endtask

  task automatic type_char(input scan_byte_t code, input ascii_t ch);
    model_char(ch);
    send_key(code);
    wait_idle();
  endtask

  task automatic type_letter(input int idx);
    ascii_t ch;
    ch = 8'h61 + 8'(idx);
    if (m_caps ^ m_shift) begin
      ch = ch - 8'h20;
    end
    type_char(letter_codes[idx], ch);
  endtask

  task automatic type_plain_random();
    int r;
    r = $urandom_range(37, 0);
    if (r < 26) begin
      type_letter(r);
    end else if (r < 36) begin
      type_char(digit_codes[r-26], 8'h30 + 8'(r - 26));
    end else begin
      type_char(8'h29, `LCD_SPACE);
    end
  endtask

  task automatic backspace();
    model_bksp();
    send_key(`SC_BKSP);
    wait_idle();
  endtask

  task automatic tap_caps();
    send_key(`SC_CAPS);
    m_caps = !m_caps;
    wait_idle();
  endtask

  task automatic hold_shift();
    shift_code = ($urandom_range(1, 0) != 0) ? `SC_RSHIFT : `SC_LSHIFT;
    send_frame(shift_code);
    m_shift = 1'b1;
    check_eq("led", int'(led), int'(shift_code));
  endtask

  task automatic release_shift();
    send_frame(`SC_BREAK);
    send_frame(shift_code);
    m_shift = 1'b0;
    check_eq("led", int'(led), int'(shift_code));
    wait_idle();
  endtask

  task automatic mixed_random();
    int r;
    r = $urandom_range(9, 0);
    case (r)
      0, 1, 2, 3: type_letter($urandom_range(25, 0));
      4: type_plain_random();
      5: backspace();
      6: tap_caps();
      7: begin
        if (m_shift) begin
          release_shift();
        end else begin
          hold_shift();
        end
      end
      8: begin
        send_key(8'h05);  // F1 has no mapping
        wait_idle();
      end
      default: type_char(8'h29, `LCD_SPACE);
    endcase
  endtask

  // display busy model
  initial begin : display_model
    int len;
    forever begin
      @(negedge clk);
      if (en) begin
        len = $urandom_range(10, 0);
        @(negedge clk);
        if (len != 0) begin
          busy = 1'b1;
          repeat (len) @(negedge clk);
          busy = 1'b0;
        end
      end
    end
  end

  initial begin : lcd_monitor
    logic [8:0] want;
    forever begin
      @(negedge clk);
      if (!rst && en) begin
        assert (exp_q.size() != 0) else begin
          fail_run("lcd transfer seen while no transfer was expected");
        end
        want = exp_q.pop_front();
        check_eq("lcd", int'({lcd.cmd, lcd.data}), int'(want));
      end
    end
  end

  initial begin
    void'($urandom(32'h8166ad5b));
    rst        = 1'b1;
    ps2_clk    = 1'b1;
    ps2_data   = 1'b1;
    busy       = 1'b0;
    m_cursor   = 0;
    m_shift    = 1'b0;
    m_caps     = 1'b0;
    shift_code = `SC_LSHIFT;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    check_eq("en", int'(en), 0);
    check_eq("led", int'(led), 0);
    check_eq("lcd", int'({lcd.cmd, lcd.data}), 0);
    repeat (200) begin
      @(negedge clk);
      check_eq("en", int'(en), 0);
    end

    backspace();  // count 0 wraps to 31
    type_plain_random();
    type_plain_random();  // line 1 command before this one
    backspace();
    for (int k = 0; k < 40; k++) begin
      type_plain_random();
    end
    for (int k = 0; k < 10; k++) begin
      backspace();
    end

    tap_caps();
    repeat (4) type_letter($urandom_range(25, 0));
    hold_shift();
    repeat (4) type_letter($urandom_range(25, 0));
    tap_caps();
    repeat (4) type_letter($urandom_range(25, 0));
    release_shift();
    repeat (4) type_letter($urandom_range(25, 0));

    for (int k = 0; k < 120; k++) begin
      mixed_random();
    end
    if (m_shift) begin
      release_shift();
    end

    wait_idle();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/ps2lcd_pkg.sv
hw/ps2_line_filter.sv
hw/ps2_frame_receiver.sv
hw/scan_decoder.sv
hw/lcd_writer.sv
hw/ps2_lcd_top.sv
testbench/tb_ps2_lcd_assertions.sv
testbench/tb_ps2_lcd.sv

// ==== Makefile ====
TOP := tb_ps2_lcd

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
